// ==== src/core.sv ====
`default_nettype none

package core;

    localparam int unsigned XLEN      = 32;
    localparam int unsigned NUM_LANES = 4;
    localparam int unsigned LANE_BITS = XLEN / NUM_LANES;

    typedef logic [XLEN-1:0]      word_t;     // Data or address word.
    typedef logic [LANE_BITS-1:0] byte_t;     // One memory lane.
    typedef logic [NUM_LANES-1:0] byte_en_t;  // One write enable per lane.
    typedef logic [1:0]           lane_off_t; // Byte offset inside a word.
    typedef logic [4:0]           reg_idx_t;  // Register file index.

    typedef enum logic [3:0] {
        MEM_NOP = 4'd0,
        LB      = 4'd1,
        LH      = 4'd2,
        LW      = 4'd3,
        LBU     = 4'd4,
        LHU     = 4'd5,
        SB      = 4'd6,
        SH      = 4'd7,
        SW      = 4'd8
    } mem_op_e;

    // Execute to write-back pipeline bus, trimmed to what memory needs.
    typedef struct packed {
        mem_op_e  mem_op;
        reg_idx_t rd;
        word_t    rd_res;         // ALU result, effective address for memory ops.
        word_t    rs2_data;       // Store data.
        word_t    pc;
        logic     rf_wr_en;
        logic     pipeline_stall;
    } pipeline_bus_t;

    typedef struct packed {
        byte_en_t  byte_en;
        lane_off_t offset;
        logic      access;        // Load or store in flight.
    } mem_cntrl_bus_t;

    function automatic logic is_load(input mem_op_e op);
        logic hit;
        case (op)
            LB, LH, LW, LBU, LHU: hit = 1'b1;
            default:              hit = 1'b0;
        endcase
        return hit;
    endfunction

    function automatic logic is_store(input mem_op_e op);
        logic hit;
        case (op)
            SB, SH, SW: hit = 1'b1;
            default:    hit = 1'b0;
        endcase
        return hit;
    endfunction

    // Halfword and word accesses carry alignment rules.
    function automatic logic is_half(input mem_op_e op);
        return (op == LH) || (op == LHU) || (op == SH);
    endfunction

    function automatic logic is_word(input mem_op_e op);
        return (op == LW) || (op == SW);
    endfunction

endpackage

`default_nettype wire

// ==== src/store_align.sv ====
`timescale 1ns/1ps
`default_nettype none

module store_align
    import core::*;
#(
    parameter int unsigned ADDR_WIDTH = 8
) (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  pipeline_bus_t         bus_i,
    output mem_cntrl_bus_t        mem_cntrl_o,
    output logic [ADDR_WIDTH-1:0] word_addr_o,
    output word_t                 lane_wdata_o,
    output pipeline_bus_t         bus_q_o,
    output mem_cntrl_bus_t        mem_cntrl_q_o
);

    lane_off_t offset;
    logic      stall;

    assign offset      = bus_i.rd_res[1:0];
    assign stall       = bus_i.pipeline_stall;
    assign word_addr_o = bus_i.rd_res[ADDR_WIDTH+1:2]; // Word address drops the lane bits.

    // Store data replication, so every lane sees its byte of the value.
    always_comb begin
        case (bus_i.mem_op)
            SB:      lane_wdata_o = {NUM_LANES{bus_i.rs2_data[7:0]}};
            SH:      lane_wdata_o = {(NUM_LANES/2){bus_i.rs2_data[15:0]}};
            default: lane_wdata_o = bus_i.rs2_data;
        endcase
    end

    // Lane enables and access flag, all suppressed while stalled.
    always_comb begin
        mem_cntrl_o        = '0;
        mem_cntrl_o.offset = offset;
        if (!stall) begin
            mem_cntrl_o.access = is_load(bus_i.mem_op) || is_store(bus_i.mem_op);
            case (bus_i.mem_op)
                SB:      mem_cntrl_o.byte_en = byte_en_t'(4'b0001) << offset;
                SH:      mem_cntrl_o.byte_en = byte_en_t'(4'b0011) << offset;
                SW:      mem_cntrl_o.byte_en = '1;
                default: mem_cntrl_o.byte_en = '0;
            endcase
        end
    end

    // Stage register toward the load controller.
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            bus_q_o        <= '0;
            bus_q_o.mem_op <= MEM_NOP;
            mem_cntrl_q_o  <= '0;
        end else if (!stall) begin
            bus_q_o       <= bus_i;
            mem_cntrl_q_o <= mem_cntrl_o;
        end
    end

    // Misaligned accesses are not trapped, so catch them here.
    property p_half_aligned;
        @(posedge clk_i) disable iff (rst_i)
            (mem_cntrl_o.access && is_half(bus_i.mem_op)) |-> (offset[0] == 1'b0);
    endproperty

    property p_word_aligned;
        @(posedge clk_i) disable iff (rst_i)
            (mem_cntrl_o.access && is_word(bus_i.mem_op)) |-> (offset == 2'b00);
    endproperty

    a_half_aligned : assert property (p_half_aligned)
        else $error("Misaligned halfword access at %h.", bus_i.rd_res);

    a_word_aligned : assert property (p_word_aligned)
        else $error("Misaligned word access at %h.", bus_i.rd_res);

endmodule

`default_nettype wire

// ==== src/byte_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module byte_bank
    import core::*;
#(
    parameter int unsigned ADDR_WIDTH = 8
) (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  access_i,
    input  logic                  we_i,
    input  logic [ADDR_WIDTH-1:0] addr_i,
    input  byte_t                 wdata_i,
    output byte_t                 rdata_o
);

    localparam int unsigned DEPTH = 2 ** ADDR_WIDTH;

    byte_t mem_q [DEPTH];
    byte_t rdata_q;

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            mem_q[addr_i] <= wdata_i;
        end
    end

    // Write-first read port.
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rdata_q <= '0;
        end else if (access_i) begin
            rdata_q <= we_i ? wdata_i : mem_q[addr_i];
        end
    end

    assign rdata_o = rdata_q;

    a_known_addr : assert property (
        @(posedge clk_i) disable iff (rst_i)
            we_i |-> !$isunknown(addr_i)
    ) else $error("Bank write with unknown address.");

endmodule

`default_nettype wire

// ==== src/load_cntrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module load_cntrl
    import core::*;
(
    input  pipeline_bus_t  bus_i,
    input  mem_cntrl_bus_t mem_cntrl_i,
    input  word_t          rdata_i,
    output pipeline_bus_t  mem2se_o
);

    word_t lane_w;  // Read word with the addressed lane moved to bit 0.
    byte_t lane_b;
    logic [15:0] lane_h;

    assign lane_w = rdata_i >> {mem_cntrl_i.offset, 3'b000};
    assign lane_b = lane_w[7:0];
    assign lane_h = lane_w[15:0];

    always_comb begin
        mem2se_o = bus_i;
        case (bus_i.mem_op)
            LB: begin
                mem2se_o.rd_res = {{24{lane_b[7]}}, lane_b}; // Sign extend.
            end
            LH: begin
                mem2se_o.rd_res = {{16{lane_h[15]}}, lane_h};
            end
            LBU, SB: begin
                mem2se_o.rd_res = {24'b0, lane_b};
            end
            LHU, SH: begin
                mem2se_o.rd_res = {16'b0, lane_h};
            end
            LW, SW: begin
                mem2se_o.rd_res = rdata_i;
            end
            default: begin
                mem2se_o.rd_res = bus_i.rd_res; // Non-memory result passes through.
            end
        endcase
    end

    // The stage register clears stall and mem_op on the same reset edge,
    // so a known stall marks the end of reset.
    always_comb begin
        if (!$isunknown(bus_i.pipeline_stall)) begin
            a_known_op : assert final (!$isunknown(bus_i.mem_op))
                else $error("Unknown mem_op after reset.");
        end
    end

endmodule

`default_nettype wire

// ==== src/mem_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_stage
    import core::*;
#(
    parameter int unsigned ADDR_WIDTH = 8
) (
    input  logic          clk_i,
    input  logic          rst_i,
    input  pipeline_bus_t bus_i,
    output pipeline_bus_t wb_bus_o
);

    mem_cntrl_bus_t        mem_cntrl;
    mem_cntrl_bus_t        mem_cntrl_q;
    logic [ADDR_WIDTH-1:0] word_addr;
    word_t                 lane_wdata;
    word_t                 rdata;     // Gathered bank read bytes.
    pipeline_bus_t         bus_q;

    store_align #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) store_align_i (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .bus_i         (bus_i),
        .mem_cntrl_o   (mem_cntrl),
        .word_addr_o   (word_addr),
        .lane_wdata_o  (lane_wdata),
        .bus_q_o       (bus_q),
        .mem_cntrl_q_o (mem_cntrl_q)
    );

    for (genvar k = 0; k < NUM_LANES; k++) begin : g_bank
        byte_bank #(
            .ADDR_WIDTH (ADDR_WIDTH)
        ) byte_bank_i (
            .clk_i    (clk_i),
            .rst_i    (rst_i),
            .access_i (mem_cntrl.access),
            .we_i     (mem_cntrl.byte_en[k]),
            .addr_i   (word_addr),
            .wdata_i  (lane_wdata[LANE_BITS*k +: LANE_BITS]),
            .rdata_o  (rdata[LANE_BITS*k +: LANE_BITS])
        );
    end

    load_cntrl load_cntrl_i (
        .bus_i       (bus_q),
        .mem_cntrl_i (mem_cntrl_q),
        .rdata_i     (rdata),
        .mem2se_o    (wb_bus_o)
    );

endmodule

`default_nettype wire

// ==== tb/tb_mem_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mem_stage
    import core::*;
();

    localparam int unsigned ADDR_WIDTH   = 8;
    localparam int unsigned MEM_BYTES    = NUM_LANES * (2 ** ADDR_WIDTH);
    localparam int unsigned RESET_CYCLES = 10;
    localparam int unsigned N_WORDS      = 16;
    localparam int unsigned N_PASS       = 12;
    localparam int unsigned STALL_CYCLES = 5;
    // Each access costs two clock cycles.
    localparam int unsigned TEST_CYCLES  = RESET_CYCLES + 2 + 4 * N_WORDS + 2 * 17 + 2 * 9
                                           + STALL_CYCLES + 6 + 2 * N_PASS;
    localparam int unsigned TIMEOUT      = 2 * TEST_CYCLES;

    logic          clk_i;
    logic          rst_i;
    pipeline_bus_t bus_i;
    pipeline_bus_t wb_bus_o;

    logic [31:0] lfsr_q;
    byte_t       shadow_mem [MEM_BYTES]; // Byte addressed model of the banks.
    int          cycle_cnt = 0;

    mem_stage #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) dut_i (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .bus_i    (bus_i),
        .wb_bus_o (wb_bus_o)
    );

    initial clk_i = 1'b0;
    always #20 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT) begin
            $display("Simulation timed out after %0d cycles.", cycle_cnt);
            $display("Test failures found");
            $fatal(1, "Timeout.");
        end
    end

    task automatic stop_on_error(input string reason);
        $display("%s", reason);
        $display("Test failures found");
        $fatal(1, "Stopping at first error.");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_bus(input string name, input pipeline_bus_t got,
                             input pipeline_bus_t exp);
        check_word({name, ".mem_op"}, word_t'(got.mem_op), word_t'(exp.mem_op));
        check_word({name, ".rd"}, word_t'(got.rd), word_t'(exp.rd));
        check_word({name, ".rd_res"}, got.rd_res, exp.rd_res);
        check_word({name, ".rs2_data"}, got.rs2_data, exp.rs2_data);
        check_word({name, ".pc"}, got.pc, exp.pc);
        check_word({name, ".rf_wr_en"}, word_t'(got.rf_wr_en), word_t'(exp.rf_wr_en));
        check_word({name, ".pipeline_stall"}, word_t'(got.pipeline_stall),
                   word_t'(exp.pipeline_stall));
    endtask

    function automatic word_t take_bits(input int unsigned n);
        word_t v;
        logic  fb;
        v = '0;
        for (int unsigned i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]; // Taps 32, 22, 2, 1.
            lfsr_q = {lfsr_q[30:0], fb};
            v      = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic word_t rand_word_addr();
        return take_bits(ADDR_WIDTH) << 2;
    endfunction

    function automatic pipeline_bus_t make_bus(input mem_op_e op, input word_t addr,
                                               input word_t data);
        pipeline_bus_t b;
        word_t         wr_en;
        b.mem_op         = op;
        b.rd             = reg_idx_t'(take_bits(5));
        b.rd_res         = addr;
        b.rs2_data       = data;
        b.pc             = take_bits(30) << 2;
        wr_en            = take_bits(1);
        b.rf_wr_en       = wr_en[0];
        b.pipeline_stall = 1'b0;
        return b;
    endfunction

    // Loaded value from the shadow memory, extended per access type.
    function automatic word_t expected_load(input mem_op_e op, input word_t addr);
        byte_t       b;
        logic [15:0] h;
        word_t       res;
        b = shadow_mem[addr];
        case (op)
            LB:  res = {{24{b[7]}}, b};
            LBU: res = {24'b0, b};
            LH: begin
                h   = {shadow_mem[addr + 1], b};
                res = {{16{h[15]}}, h};
            end
            LHU: begin
                h   = {shadow_mem[addr + 1], b};
                res = {16'b0, h};
            end
            LW:  res = {shadow_mem[addr + 3], shadow_mem[addr + 2], shadow_mem[addr + 1], b};
            default: res = 'x;
        endcase
        return res;
    endfunction

    task automatic issue_bus(input pipeline_bus_t b, output pipeline_bus_t r);
        @(posedge clk_i);
        bus_i <= b;
        @(posedge clk_i); // DUT registers b here.
        bus_i <= '0;
        @(negedge clk_i);
        r = wb_bus_o;
    endtask

    task automatic run_access(input mem_op_e op, input word_t addr, input word_t data);
        pipeline_bus_t b;
        pipeline_bus_t exp;
        pipeline_bus_t got;
        b   = make_bus(op, addr, data);
        exp = b;
        case (op)
            SB: begin
                shadow_mem[addr] = data[7:0];
                exp.rd_res       = {24'b0, data[7:0]};
            end
            SH: begin
                shadow_mem[addr]     = data[7:0];
                shadow_mem[addr + 1] = data[15:8];
                exp.rd_res           = {16'b0, data[15:0]};
            end
            SW: begin
                for (int k = 0; k < 4; k++) begin
                    shadow_mem[addr + k] = data[8*k +: 8];
                end
                exp.rd_res = data;
            end
            default: exp.rd_res = expected_load(op, addr);
        endcase
        issue_bus(b, got);
        check_bus("wb_bus_o", got, exp);
    endtask

    task automatic test_reset();
        pipeline_bus_t exp;
        exp        = '0;
        exp.mem_op = MEM_NOP;
        @(negedge clk_i);
        check_bus("wb_bus_o", wb_bus_o, exp);
    endtask

    task automatic test_word_access();
        word_t addrs [N_WORDS];
        for (int i = 0; i < N_WORDS; i++) begin
            addrs[i] = rand_word_addr();
            run_access(SW, addrs[i], take_bits(32));
        end
        for (int i = 0; i < N_WORDS; i++) begin
            run_access(LW, addrs[i], take_bits(32));
        end
    endtask

    task automatic test_byte_access();
        word_t base;
        base = rand_word_addr();
        run_access(SW, base, take_bits(32));
        for (int k = 0; k < 4; k++) begin
            run_access(SB, base + k, take_bits(32));
            run_access(LW, base, take_bits(32)); // Other lanes unchanged.
        end
        for (int k = 0; k < 4; k++) begin
            run_access(LB, base + k, take_bits(32));
            run_access(LBU, base + k, take_bits(32));
        end
    endtask

    task automatic test_half_access();
        word_t base;
        base = rand_word_addr();
        run_access(SW, base, take_bits(32));
        for (int k = 0; k < 4; k += 2) begin
            run_access(SH, base + k, take_bits(32));
            run_access(LH, base + k, take_bits(32));
            run_access(LHU, base + k, take_bits(32));
            run_access(LW, base, take_bits(32));
        end
    endtask

    task automatic test_stall_hold();
        word_t         addr;
        pipeline_bus_t stalled;
        pipeline_bus_t idle;
        addr        = rand_word_addr();
        idle        = '0;
        idle.mem_op = MEM_NOP; // Idle bus registered just before the stall.
        run_access(SW, addr, take_bits(32));
        stalled                = make_bus(SW, addr, take_bits(32));
        stalled.pipeline_stall = 1'b1;
        @(posedge clk_i);
        bus_i <= stalled;
        repeat (STALL_CYCLES) begin
            @(negedge clk_i);
            check_bus("wb_bus_o", wb_bus_o, idle);
        end
        @(posedge clk_i);
        bus_i <= '0;
        run_access(LW, addr, take_bits(32)); // Shadow still holds the old word.
    endtask

    task automatic test_pass_through();
        pipeline_bus_t b;
        pipeline_bus_t got;
        for (int i = 0; i < N_PASS; i++) begin
            b = make_bus(MEM_NOP, take_bits(32), take_bits(32));
            issue_bus(b, got);
            check_bus("wb_bus_o", got, b);
        end
    endtask

    initial begin
        rst_i  = 1'b1;
        bus_i  = '0;
        lfsr_q = 32'heda96051;
        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_i <= 1'b0;
        test_reset();
        test_word_access();
        test_byte_access();
        test_half_access();
        test_stall_hold();
        test_pass_through();
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

// ==== mem_stage.f ====
src/core.sv
src/store_align.sv
src/byte_bank.sv
src/load_cntrl.sv
src/mem_stage.sv
tb/tb_mem_stage.sv

// ==== Bender.yml ====
package:
  name: mem_stage

sources:
  - src/core.sv
  - src/store_align.sv
  - src/byte_bank.sv
  - src/load_cntrl.sv
  - src/mem_stage.sv
  - target: test
    files:
      - tb/tb_mem_stage.sv
